// ==== design/bp_pkg.sv ====
// sizes, vector typedefs, jump type enum, resolve, prediction and entry structs
package bp_pkg;

  localparam logic [31:0] RESET_PC = 32'h1c00_0000;

  localparam int BTB_SIZE  = 64;
  localparam int BTB_IDX_W = 6;
  localparam int BTB_TAG_W = 8;

  localparam int QUEUE_SIZE  = 8;
  localparam int QUEUE_IDX_W = 3;

  localparam int STAT_W = 32;

  typedef logic [31:0]            addr_t;
  typedef logic [29:0]            word_addr_t;
  typedef logic [BTB_IDX_W-1:0]   btb_idx_t;
  typedef logic [BTB_TAG_W-1:0]   btb_tag_t;
  typedef logic [1:0]             counter_t;
  typedef logic [3:0]             slot_mask_t;
  typedef logic [QUEUE_IDX_W-1:0] queue_idx_t;
  typedef logic [STAT_W-1:0]      stat_t;

  typedef enum logic [1:0] {
    JUMP_COND     = 2'd0,
    JUMP_DIRECT   = 2'd1,
    JUMP_INDIRECT = 2'd2,
    JUMP_CALL     = 2'd3
  } jump_type_e;

  // one execute-stage result, 70 bits, flush on top
  typedef struct packed {
    logic       flush;
    addr_t      pc;
    logic       valid;
    logic       taken;
    logic       pre_fail;
    addr_t      target;
    jump_type_e jump_type;
  } resolve_t;

  // lookup result for the current fetch group
  typedef struct packed {
    addr_t      next_pc;
    slot_mask_t slot_valid;
    slot_mask_t slot_jump;
  } pred_t;

  // target buffer line, counter kept apart
  typedef struct packed {
    jump_type_e jump_type;
    btb_tag_t   tag;
    word_addr_t target;
  } entry_t;

endpackage

// ==== design/fetch_pc_reg.sv ====
// fetch pc register with reset vector, stall hold and redirect load
`timescale 1ns/1ps

module fetch_pc_reg (
  input  logic          clk,
  input  logic          reset,
  input  logic          stall,
  input  logic          redirect,
  input  bp_pkg::addr_t redirect_pc,
  input  bp_pkg::addr_t next_pc,
  output bp_pkg::addr_t fetch_pc
);

  // redirect beats stall, stall beats prediction
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      fetch_pc <= bp_pkg::RESET_PC;
    end
    else if (redirect)
    begin
      fetch_pc <= redirect_pc;
    end
    else if (!stall)
    begin
      fetch_pc <= next_pc;
    end
  end

endmodule

// ==== design/btb_pht_table.sv ====
// branch target buffer with 2-bit counters, four group read slots, two training ports
`timescale 1ns/1ps

module btb_pht_table (
  input  logic                    clk,
  input  logic                    reset,
  input  bp_pkg::addr_t           fetch_pc,
  output bp_pkg::entry_t [3:0]    rd_entry,
  output bp_pkg::slot_mask_t      rd_hit,
  output bp_pkg::counter_t [3:0]  rd_counter,
  input  bp_pkg::resolve_t        train_0,
  input  bp_pkg::resolve_t        train_1,
  output logic                    wr_valid_0,
  output logic                    wr_valid_1
);

  logic [bp_pkg::BTB_SIZE-1:0] valid;
  bp_pkg::entry_t              entry [bp_pkg::BTB_SIZE];
  bp_pkg::counter_t            counter [bp_pkg::BTB_SIZE];

  bp_pkg::btb_tag_t rd_tag;
  bp_pkg::btb_idx_t rd_idx [4];

  bp_pkg::btb_idx_t w_idx_0;
  bp_pkg::btb_idx_t w_idx_1;

  logic             nv_0;
  logic             nv_1;
  bp_pkg::entry_t   ne_0;
  bp_pkg::entry_t   ne_1;
  bp_pkg::counter_t nc_0;
  bp_pkg::counter_t nc_1;

  logic             base_v_1;
  bp_pkg::entry_t   base_e_1;
  bp_pkg::counter_t base_c_1;

  // next state of one line after a single resolve
  function automatic void train_step(
    input  bp_pkg::resolve_t r,
    input  logic             v_in,
    input  bp_pkg::entry_t   e_in,
    input  bp_pkg::counter_t c_in,
    output logic             v_out,
    output bp_pkg::entry_t   e_out,
    output bp_pkg::counter_t c_out
  );
    bp_pkg::btb_tag_t tag;
    tag   = r.pc[bp_pkg::BTB_IDX_W+2 +: bp_pkg::BTB_TAG_W];
    v_out = v_in;
    e_out = e_in;
    c_out = c_in;
    if (r.valid && r.taken)
    begin
      e_out.jump_type = r.jump_type;
      e_out.tag       = tag;
      e_out.target    = r.target[31:2];
      // new or replaced line starts weakly taken
      if (!v_in || e_in.tag != tag)
      begin
        v_out = 1'b1;
        c_out = 2'd2;
      end
      else
      begin
        c_out = (c_in == 2'd3) ? 2'd3 : c_in + 2'd1;
      end
    end
    else if (r.valid && v_in)
    begin
      c_out = (c_in == 2'd0) ? 2'd0 : c_in - 2'd1;
    end
  endfunction

  // group aligned read, slots 0..3
  always_comb
  begin
    rd_tag = fetch_pc[bp_pkg::BTB_IDX_W+2 +: bp_pkg::BTB_TAG_W];
    for (int i = 0; i < 4; i++)
    begin
      rd_idx[i]     = {fetch_pc[bp_pkg::BTB_IDX_W+1:4], 2'(i)};
      rd_entry[i]   = entry[rd_idx[i]];
      rd_counter[i] = counter[rd_idx[i]];
      rd_hit[i]     = valid[rd_idx[i]] && (entry[rd_idx[i]].tag == rd_tag);
    end
  end

  assign w_idx_0    = train_0.pc[2 +: bp_pkg::BTB_IDX_W];
  assign w_idx_1    = train_1.pc[2 +: bp_pkg::BTB_IDX_W];
  assign wr_valid_0 = valid[w_idx_0];
  assign wr_valid_1 = valid[w_idx_1];

  // port 1 sees the result of port 0 on a shared index
  always_comb
  begin
    train_step(train_0, valid[w_idx_0], entry[w_idx_0], counter[w_idx_0], nv_0, ne_0, nc_0);
    if (w_idx_1 == w_idx_0)
    begin
      base_v_1 = nv_0;
      base_e_1 = ne_0;
      base_c_1 = nc_0;
    end
    else
    begin
      base_v_1 = valid[w_idx_1];
      base_e_1 = entry[w_idx_1];
      base_c_1 = counter[w_idx_1];
    end
    train_step(train_1, base_v_1, base_e_1, base_c_1, nv_1, ne_1, nc_1);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid <= '0;
    end
    else
    begin
      if (train_0.valid)
        valid[w_idx_0] <= nv_0;
      if (train_1.valid)
        valid[w_idx_1] <= nv_1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (train_0.valid)
    begin
      entry[w_idx_0]   <= ne_0;
      counter[w_idx_0] <= nc_0;
    end
    if (train_1.valid)
    begin
      entry[w_idx_1]   <= ne_1;
      counter[w_idx_1] <= nc_1;
    end
  end

endmodule

// ==== design/group_predict.sv ====
// group slot mask and choice of the first predicted-taken slot
`timescale 1ns/1ps

module group_predict (
  input  bp_pkg::addr_t           fetch_pc,
  input  bp_pkg::entry_t [3:0]    rd_entry,
  input  bp_pkg::slot_mask_t      rd_hit,
  input  bp_pkg::counter_t [3:0]  rd_counter,
  output bp_pkg::pred_t           pred
);

  bp_pkg::slot_mask_t group_mask;
  bp_pkg::slot_mask_t slot_taken;

  // slots before the fetch pc are not part of this group
  always_comb
  begin
    case (fetch_pc[3:2])
      2'd0:    group_mask = 4'b1111;
      2'd1:    group_mask = 4'b1110;
      2'd2:    group_mask = 4'b1100;
      default: group_mask = 4'b1000;
    endcase
  end

  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      slot_taken[i] = rd_hit[i] && (rd_counter[i] >= 2'd2) && group_mask[i];
    end
  end

  // walk down so the lowest taken slot is written last
  always_comb
  begin
    pred.next_pc    = {fetch_pc[31:4] + 28'd1, 4'b0000};
    pred.slot_valid = group_mask;
    pred.slot_jump  = '0;
    for (int i = 3; i >= 0; i--)
    begin
      if (slot_taken[i])
      begin
        pred.next_pc    = {rd_entry[i].target, 2'b00};
        pred.slot_valid = group_mask & bp_pkg::slot_mask_t'((5'd1 << (i + 1)) - 5'd1);
        pred.slot_jump  = bp_pkg::slot_mask_t'(4'b0001 << i);
      end
    end
  end

endmodule

// ==== design/predict_queue.sv ====
// in-order queue of predicted jump targets with push, pop and clear
`timescale 1ns/1ps

module predict_queue (
  input  logic               clk,
  input  logic               reset,
  input  logic               push,
  input  bp_pkg::word_addr_t push_target,
  input  logic               pop,
  input  logic               clear,
  output bp_pkg::word_addr_t head,
  output logic               head_valid
);

  bp_pkg::word_addr_t            mem [bp_pkg::QUEUE_SIZE];
  logic [bp_pkg::QUEUE_SIZE-1:0] entry_valid;
  bp_pkg::queue_idx_t            head_ptr;
  bp_pkg::queue_idx_t            tail_ptr;
  logic                          full;
  logic                          do_push;

  assign full       = entry_valid[tail_ptr];
  assign do_push    = push && !full;
  assign head       = mem[head_ptr];
  assign head_valid = entry_valid[head_ptr];

  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      entry_valid <= '0;
      head_ptr    <= '0;
      tail_ptr    <= '0;
    end
    else
    begin
      if (pop && head_valid)
      begin
        entry_valid[head_ptr] <= 1'b0;
        head_ptr              <= head_ptr + bp_pkg::queue_idx_t'(1);
      end
      // full queue drops the push
      if (do_push)
      begin
        entry_valid[tail_ptr] <= 1'b1;
        tail_ptr              <= tail_ptr + bp_pkg::queue_idx_t'(1);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push && !clear)
      mem[tail_ptr] <= push_target;
  end

endmodule

// ==== design/resolve_check.sv ====
// misprediction check, redirect select, queue pop and resolve statistics
`timescale 1ns/1ps

module resolve_check (
  input  logic               clk,
  input  logic               reset,
  input  bp_pkg::resolve_t   resolve_0,
  input  bp_pkg::resolve_t   resolve_1,
  input  logic               wr_valid_0,
  input  logic               wr_valid_1,
  input  bp_pkg::word_addr_t head,
  input  logic               head_valid,
  output logic               redirect,
  output bp_pkg::addr_t      redirect_pc,
  output logic               pop,
  output bp_pkg::stat_t      num_resolved,
  output bp_pkg::stat_t      num_correct
);

  logic checked_0;
  logic checked_1;
  logic mispredict_0;
  logic mispredict_1;
  logic correct_0;
  logic correct_1;

  // taken branch that was in the table while a prediction is pending
  assign checked_0 = resolve_0.valid && resolve_0.taken && !resolve_0.pre_fail &&
                     wr_valid_0 && head_valid;
  assign checked_1 = resolve_1.valid && resolve_1.taken && !resolve_1.pre_fail &&
                     wr_valid_1 && head_valid;

  assign mispredict_0 = checked_0 && (resolve_0.target[31:2] != head);
  assign mispredict_1 = checked_1 && (resolve_1.target[31:2] != head);
  assign correct_0    = checked_0 && (resolve_0.target[31:2] == head);
  assign correct_1    = checked_1 && (resolve_1.target[31:2] == head);

  assign redirect    = resolve_0.flush || resolve_1.flush || mispredict_0 || mispredict_1;
  // older slot wins the redirect target
  assign redirect_pc = (resolve_0.flush || mispredict_0) ? resolve_0.target : resolve_1.target;
  assign pop         = (correct_0 || correct_1) && !redirect;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      num_resolved <= '0;
      num_correct  <= '0;
    end
    else
    begin
      num_resolved <= num_resolved + bp_pkg::stat_t'(resolve_0.valid) +
                      bp_pkg::stat_t'(resolve_1.valid);
      if (!redirect)
      begin
        num_correct <= num_correct + bp_pkg::stat_t'(resolve_0.valid) +
                       bp_pkg::stat_t'(resolve_1.valid);
      end
    end
  end

endmodule

// ==== design/branch_predict_top.sv ====
// branch prediction front end: fetch pc, target buffer, group predict, queue, resolve
`timescale 1ns/1ps

module branch_predict_top (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  bp_pkg::resolve_t resolve_0,
  input  bp_pkg::resolve_t resolve_1,
  output bp_pkg::addr_t    fetch_pc,
  output bp_pkg::pred_t    pred,
  output logic             redirect,
  output bp_pkg::addr_t    redirect_pc,
  output bp_pkg::stat_t    num_resolved,
  output bp_pkg::stat_t    num_correct
);

  bp_pkg::entry_t [3:0]   rd_entry;
  bp_pkg::slot_mask_t     rd_hit;
  bp_pkg::counter_t [3:0] rd_counter;
  logic                   wr_valid_0;
  logic                   wr_valid_1;
  bp_pkg::word_addr_t     head;
  logic                   head_valid;
  logic                   pop;

  fetch_pc_reg fetch_pc_reg_i (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .next_pc     (pred.next_pc),
    .fetch_pc    (fetch_pc)
  );

  btb_pht_table btb_pht_table_i (
    .clk        (clk),
    .reset      (reset),
    .fetch_pc   (fetch_pc),
    .rd_entry   (rd_entry),
    .rd_hit     (rd_hit),
    .rd_counter (rd_counter),
    .train_0    (resolve_0),
    .train_1    (resolve_1),
    .wr_valid_0 (wr_valid_0),
    .wr_valid_1 (wr_valid_1)
  );

  group_predict group_predict_i (
    .fetch_pc   (fetch_pc),
    .rd_entry   (rd_entry),
    .rd_hit     (rd_hit),
    .rd_counter (rd_counter),
    .pred       (pred)
  );

  // a predicted jump is recorded only when fetch moves on
  predict_queue predict_queue_i (
    .clk         (clk),
    .reset       (reset),
    .push        (|pred.slot_jump && !stall),
    .push_target (pred.next_pc[31:2]),
    .pop         (pop),
    .clear       (redirect),
    .head        (head),
    .head_valid  (head_valid)
  );

  resolve_check resolve_check_i (
    .clk          (clk),
    .reset        (reset),
    .resolve_0    (resolve_0),
    .resolve_1    (resolve_1),
    .wr_valid_0   (wr_valid_0),
    .wr_valid_1   (wr_valid_1),
    .head         (head),
    .head_valid   (head_valid),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .pop          (pop),
    .num_resolved (num_resolved),
    .num_correct  (num_correct)
  );

endmodule

// ==== verification/branch_predict_tb.sv ====
// branch prediction front end testbench with stimulus table, reference model and checks
`timescale 1ns/1ps

module branch_predict_tb;

  localparam int NUM_ROWS       = 72;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 + 100;

  typedef struct packed {
    logic             stall;
    bp_pkg::resolve_t r0;
    bp_pkg::resolve_t r1;
  } row_t;

  logic             clk;
  logic             reset;
  logic             stall;
  bp_pkg::resolve_t resolve_0;
  bp_pkg::resolve_t resolve_1;
  bp_pkg::addr_t    fetch_pc;
  bp_pkg::pred_t    pred;
  logic             redirect;
  bp_pkg::addr_t    redirect_pc;
  bp_pkg::stat_t    num_resolved;
  bp_pkg::stat_t    num_correct;

  row_t        rows [NUM_ROWS];
  int          n_rows;
  int          cur_row;
  int          cycles;
  int          err_addr;
  int          err_pred;
  int          err_stat;
  int          err_bit;
  logic [31:0] lfsr;

  // reference model of table, queue, fetch pc and counters
  logic [bp_pkg::BTB_SIZE-1:0] m_valid;
  bp_pkg::entry_t              m_entry [bp_pkg::BTB_SIZE];
  bp_pkg::counter_t            m_counter [bp_pkg::BTB_SIZE];
  bp_pkg::word_addr_t          m_q [$];
  bp_pkg::addr_t               m_pc;
  bp_pkg::stat_t               m_resolved;
  bp_pkg::stat_t               m_correct;

  branch_predict_top branch_predict_top_i (.*);

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b)
        lfsr = lfsr ^ 32'h8020_0003;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic bp_pkg::resolve_t flush_to(input bp_pkg::addr_t target);
    bp_pkg::resolve_t r;
    r        = '0;
    r.flush  = 1'b1;
    r.target = target;
    return r;
  endfunction

  function automatic bp_pkg::resolve_t branch_at(input bp_pkg::addr_t pc, input logic taken,
                                                 input bp_pkg::addr_t target);
    bp_pkg::resolve_t r;
    logic [31:0]      jt;
    jt          = rand_bits(2);
    r           = '0;
    r.pc        = pc;
    r.valid     = 1'b1;
    r.taken     = taken;
    r.target    = target;
    r.jump_type = bp_pkg::jump_type_e'(jt[1:0]);
    return r;
  endfunction

  // branches and targets near base that sometimes reuse the trained target
  function automatic bp_pkg::resolve_t random_resolve(input bp_pkg::addr_t base,
                                                      input bp_pkg::addr_t hint);
    bp_pkg::resolve_t r;
    logic [31:0]      f;
    logic [31:0]      a;
    f          = rand_bits(8);
    a          = rand_bits(12);
    r          = branch_at({base[31:8], a[5:0], 2'b00}, f[0],
                           f[1] ? hint : {base[31:8], a[11:6], 2'b00});
    r.valid    = f[2] | f[3];
    r.pre_fail = f[4] & f[0];
    r.flush    = &f[7:5];
    return r;
  endfunction

  task automatic add_row(input logic s, input bp_pkg::resolve_t r0, input bp_pkg::resolve_t r1);
    rows[n_rows] = {s, r0, r1};
    n_rows++;
  endtask

  task automatic build_table();
    bp_pkg::addr_t    b;
    bp_pkg::addr_t    g;
    bp_pkg::addr_t    t;
    bp_pkg::addr_t    t2;
    bp_pkg::addr_t    x;
    bp_pkg::resolve_t idle;
    logic [31:0]      rb;
    idle = '0;
    rb   = rand_bits(12);
    // branch sits in slot 1 of its group
    b    = {16'h1c00, rb[11:0], 4'b0100};
    g    = {b[31:4], 4'h0};
    rb   = rand_bits(30);
    t    = {rb[29:0], 2'b00};
    t2   = t ^ 32'h0000_0100;
    rb   = rand_bits(12);
    x    = {16'h1c01, rb[11:0], 4'b1000};
    repeat (6) add_row(1'b0, idle, idle);
    add_row(1'b0, flush_to(x), idle);
    repeat (2) add_row(1'b0, idle, idle);
    add_row(1'b0, branch_at(b, 1'b1, t), idle);
    add_row(1'b0, flush_to(g), idle);
    repeat (3) add_row(1'b0, idle, idle);
    // wrong target against the queue head and later the right one on port 1
    add_row(1'b0, branch_at(b, 1'b1, t2), idle);
    add_row(1'b0, idle, idle);
    add_row(1'b0, flush_to(g), idle);
    add_row(1'b0, idle, idle);
    add_row(1'b0, idle, branch_at(b, 1'b1, t2));
    add_row(1'b0, idle, idle);
    // both ports on one index take the counter from 3 down to 1
    add_row(1'b0, branch_at(b, 1'b0, t2), branch_at(b, 1'b0, t2));
    add_row(1'b0, flush_to(g), idle);
    repeat (2) add_row(1'b0, idle, idle);
    add_row(1'b0, flush_to(g), idle);
    add_row(1'b1, branch_at(b, 1'b1, t2), idle);
    repeat (2) add_row(1'b1, idle, idle);
    repeat (2) add_row(1'b0, idle, idle);
    add_row(1'b0, branch_at(b ^ 32'h40, 1'b1, t), branch_at(b ^ 32'h80, 1'b0, t));
    add_row(1'b0, branch_at(b ^ 32'h40, 1'b1, t), flush_to(g));
    while (n_rows < NUM_ROWS)
    begin
      rb = rand_bits(2);
      add_row(&rb[1:0], random_resolve(b, t2), random_resolve(b, t2));
    end
  endtask

  function automatic bp_pkg::pred_t expect_pred(input bp_pkg::addr_t pc);
    bp_pkg::pred_t      p;
    bp_pkg::slot_mask_t mask;
    bp_pkg::btb_idx_t   idx;
    logic               found;
    mask         = 4'b1111 << pc[3:2];
    p.next_pc    = {pc[31:4], 4'h0} + 32'd16;
    p.slot_valid = mask;
    p.slot_jump  = '0;
    found        = 1'b0;
    for (int s = 0; s < 4; s++)
    begin
      idx = {pc[7:4], s[1:0]};
      if (!found && mask[s] && m_valid[idx] && m_entry[idx].tag == pc[15:8] &&
          m_counter[idx] >= 2'd2)
      begin
        found        = 1'b1;
        p.next_pc    = {m_entry[idx].target, 2'b00};
        p.slot_valid = mask & ~(4'b1110 << s);
        p.slot_jump  = 4'b0001 << s;
      end
    end
    return p;
  endfunction

  // bit 1 is a mispredict and bit 0 a confirmed prediction
  function automatic logic [1:0] port_result(input bp_pkg::resolve_t r);
    if (!(r.valid && r.taken && !r.pre_fail && m_valid[r.pc[7:2]] && m_q.size() != 0))
      return 2'b00;
    return (r.target[31:2] != m_q[0]) ? 2'b10 : 2'b01;
  endfunction

  task automatic train_line(input bp_pkg::resolve_t r);
    bp_pkg::btb_idx_t idx;
    idx = r.pc[7:2];
    if (r.valid && r.taken)
    begin
      if (!m_valid[idx] || m_entry[idx].tag != r.pc[15:8])
      begin
        m_valid[idx]   = 1'b1;
        m_counter[idx] = 2'd2;
      end
      else if (m_counter[idx] != 2'd3)
        m_counter[idx] = m_counter[idx] + 2'd1;
      m_entry[idx] = {r.jump_type, r.pc[15:8], r.target[31:2]};
    end
    else if (r.valid && m_valid[idx] && m_counter[idx] != 2'd0)
      m_counter[idx] = m_counter[idx] - 2'd1;
  endtask

  task automatic model_step(input row_t row, input bp_pkg::pred_t p, input logic redir,
                            input bp_pkg::addr_t rpc, input logic pop);
    logic push_ok;
    push_ok = (p.slot_jump != '0) && !row.stall && (m_q.size() < bp_pkg::QUEUE_SIZE);
    if (redir)
      m_pc = rpc;
    else if (!row.stall)
      m_pc = p.next_pc;
    if (redir)
      m_q.delete();
    else
    begin
      if (pop)
        void'(m_q.pop_front());
      if (push_ok)
        m_q.push_back(p.next_pc[31:2]);
    end
    train_line(row.r0);
    train_line(row.r1);
    m_resolved = m_resolved + bp_pkg::stat_t'(row.r0.valid) + bp_pkg::stat_t'(row.r1.valid);
    if (!redir)
      m_correct = m_correct + bp_pkg::stat_t'(row.r0.valid) + bp_pkg::stat_t'(row.r1.valid);
  endtask

  task automatic check_addr(input string name, input bp_pkg::addr_t got, input bp_pkg::addr_t exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h (row %0d)", name, got, exp, cur_row);
      err_addr++;
    end
  endtask

  task automatic check_pred(input bp_pkg::pred_t got, input bp_pkg::pred_t exp);
    if (got !== exp)
    begin
      $display("mismatch pred: got %h/%h/%h expected %h/%h/%h (row %0d)", got.next_pc,
               got.slot_valid, got.slot_jump, exp.next_pc, exp.slot_valid, exp.slot_jump,
               cur_row);
      err_pred++;
    end
  endtask

  task automatic check_stat(input string name, input bp_pkg::stat_t got, input bp_pkg::stat_t exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h (row %0d)", name, got, exp, cur_row);
      err_stat++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch %s: got %h expected %h (row %0d)", name, got, exp, cur_row);
      err_bit++;
    end
  endtask

  initial
  begin
    bp_pkg::pred_t exp_pred;
    bp_pkg::addr_t exp_rpc;
    logic          exp_redirect;
    logic          exp_pop;
    logic [1:0]    res_0;
    logic [1:0]    res_1;
    clk        = 1'b0;
    reset      = 1'b1;
    stall      = 1'b0;
    resolve_0  = '0;
    resolve_1  = '0;
    cycles     = 0;
    n_rows     = 0;
    err_addr   = 0;
    err_pred   = 0;
    err_stat   = 0;
    err_bit    = 0;
    lfsr       = 32'hb695_3e65;
    m_valid    = '0;
    m_pc       = bp_pkg::RESET_PC;
    m_resolved = '0;
    m_correct  = '0;
    m_q.delete();
    build_table();
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      cur_row   = i;
      stall     <= rows[i].stall;
      resolve_0 <= rows[i].r0;
      resolve_1 <= rows[i].r1;
      @(negedge clk);
      exp_pred     = expect_pred(m_pc);
      res_0        = port_result(rows[i].r0);
      res_1        = port_result(rows[i].r1);
      exp_redirect = rows[i].r0.flush || rows[i].r1.flush || res_0[1] || res_1[1];
      exp_rpc      = (rows[i].r0.flush || res_0[1]) ? rows[i].r0.target : rows[i].r1.target;
      exp_pop      = (res_0[0] || res_1[0]) && !exp_redirect;
      check_addr("fetch_pc", fetch_pc, m_pc);
      check_pred(pred, exp_pred);
      check_bit("redirect", redirect, exp_redirect);
      if (exp_redirect)
        check_addr("redirect_pc", redirect_pc, exp_rpc);
      check_stat("num_resolved", num_resolved, m_resolved);
      check_stat("num_correct", num_correct, m_correct);
      model_step(rows[i], exp_pred, exp_redirect, exp_rpc, exp_pop);
      @(posedge clk);
    end
    // state left behind by the last row
    cur_row = NUM_ROWS;
    @(negedge clk);
    check_addr("fetch_pc", fetch_pc, m_pc);
    check_stat("num_resolved", num_resolved, m_resolved);
    check_stat("num_correct", num_correct, m_correct);
    $display("errors: addr %0d, pred %0d, stat %0d, redirect %0d",
             err_addr, err_pred, err_stat, err_bit);
    if (err_addr + err_pred + err_stat + err_bit == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== flist.f ====
design/bp_pkg.sv
design/fetch_pc_reg.sv
design/btb_pht_table.sv
design/group_predict.sv
design/predict_queue.sv
design/resolve_check.sv
design/branch_predict_top.sv
verification/branch_predict_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the branch prediction testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module branch_predict_tb -f flist.f
out=$(./obj_dir/Vbranch_predict_tb)
echo "$out"
if echo "$out" | grep -qxF "PASS: all tests"; then
  exit 0
fi
exit 1
